/* Bender.yml */
package:
  name: lcd_display

sources:
  - source/lcd_pkg.sv
  - source/lcd_text_buffer.sv
  - source/lcd_refresh_seq.sv
  - source/lcd_controller.sv
  - source/lcd_display_top.sv
  - target: test
    files:
      - dv/lcd_sva.sv
      - dv/lcd_tb.sv

/* dv/lcd_sva.sv */
`timescale 1ns/1ns
module lcd_sva
	import lcd_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic e,
	input logic rw,
	input logic busy,
	input logic lcd_enable
);
	int fail_count = 0; // failed assertions so far

	// enable pulse only inside a busy window
	a_e_in_busy: assert property (@(posedge clk) disable iff (!rst_n) e |-> busy)
		else begin
			$error("lcd_e high while busy is low");
			fail_count++;
		end

	a_rw_low: assert property (@(posedge clk) disable iff (!rst_n) !rw)
		else begin
			$error("lcd_rw driven high");
			fail_count++;
		end

	// strobe only reaches an idle controller
	a_enable_idle: assert property (@(posedge clk) disable iff (!rst_n) lcd_enable |-> !busy)
		else begin
			$error("lcd_enable raised while busy is high");
			fail_count++;
		end

	a_busy_falls: assert property (@(posedge clk) disable iff (!rst_n)
		(lcd_enable && !busy) |=> busy ##[1:XFER_CYC] !busy)
		else begin
			$error("busy did not fall within the transfer time");
			fail_count++;
		end
endmodule

bind lcd_controller lcd_sva sva0 (
	.clk        (clk),
	.rst_n      (rst_n),
	.e          (e),
	.rw         (rw),
	.busy       (busy),
	.lcd_enable (lcd_enable)
);

/* dv/lcd_tb.sv */
`timescale 1ns/1ns
module lcd_tb
	import lcd_pkg::*;
();
	localparam int XFERS         = 2 * LINE_LEN + 2;         // two address commands plus chars
	localparam int BOOT_LIMIT    = PWR_CYC + INIT_CYC + 20;
	localparam int REFRESH_LIMIT = XFERS * (XFER_CYC + 20);
	localparam int WATCHDOG_NS   = (BOOT_LIMIT + 5 * REFRESH_LIMIT) * 10;

	logic              clk;
	logic              rst_n;
	logic [6:0]        cfg;
	logic              char_we;
	logic [ADDR_W-1:0] char_addr;
	logic [7:0]        char_data;
	logic              refresh;
	logic              ready;
	logic              lcd_e;
	logic              lcd_rs;
	logic              lcd_rw;
	logic [7:0]        lcd_data;

	integer     seed;
	int         cyc = 0;
	logic       e_last = 1'b0;
	logic [9:0] cap_q[$];        // {rs, rw, data} per enable pulse
	int         rise_q[$];
	int         fall_q[$];
	logic [7:0] model[NUM_CHARS];

	lcd_display_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.char_we   (char_we),
		.char_addr (char_addr),
		.char_data (char_data),
		.refresh   (refresh),
		.ready     (ready),
		.lcd_e     (lcd_e),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_data  (lcd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout at %0t, the tests did not finish in time", $time);
		$display("Errors found");
		$fatal(1);
	end

	always @(dut0.u_ctrl.sva0.fail_count) begin
		if (dut0.u_ctrl.sva0.fail_count != 0) begin
			report_failure("an assertion on the LCD controller failed");
		end
	end

	// pins are stable at the falling clock edge
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (!e_last && lcd_e) begin
			rise_q.push_back(cyc);
		end
		if (e_last && !lcd_e) begin // data still held here
			fall_q.push_back(cyc);
			cap_q.push_back({lcd_rs, lcd_rw, lcd_data});
		end
		e_last = lcd_e;
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s (time %0t)", what, $time);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic wait_ready(input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!ready && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!ready) begin
			report_failure($sformatf("ready did not rise within %0d cycles after %s", limit, what));
		end
	endtask

	task automatic pulse_refresh();
		@(posedge clk);
		refresh <= 1'b1;
		@(posedge clk);
		refresh <= 1'b0;
	endtask

	task automatic run_refresh(input string what);
		cap_q.delete();
		rise_q.delete();
		fall_q.delete();
		pulse_refresh();
		wait_ready(REFRESH_LIMIT, what);
	endtask

	// expected frame: line 0 address, 16 chars, line 1 address, 16 chars
	task automatic check_frame(input string what);
		logic [9:0] exp;
		check({what, " capture count"}, XFERS, cap_q.size());
		for (int i = 0; i < XFERS; i++) begin
			if (i == 0) begin
				exp = {2'b00, OP_SET_DDRAM};
			end else if (i == LINE_LEN + 1) begin
				exp = {2'b00, OP_SET_DDRAM | LINE1_BASE};
			end else if (i <= LINE_LEN) begin
				exp = {2'b10, model[i-1]};
			end else begin
				exp = {2'b10, model[i-2]};
			end
			check($sformatf("%s lcd word %0d", what, i), exp, cap_q[i]);
		end
	endtask

	task automatic init_sequence();
		logic [7:0] exp_bytes[4];
		exp_bytes[0] = OP_FUNC_SET | ({7'b0, cfg[CFG_LINES]} << 3) | ({7'b0, cfg[CFG_FONT]} << 2);
		exp_bytes[1] = OP_DISP_CTRL | ({7'b0, cfg[CFG_DISP]} << 2)
			| ({7'b0, cfg[CFG_CURSOR]} << 1) | {7'b0, cfg[CFG_BLINK]};
		exp_bytes[2] = OP_CLEAR;
		exp_bytes[3] = OP_ENTRY_MODE | ({7'b0, cfg[CFG_INC]} << 1) | {7'b0, cfg[CFG_SHIFT]};
		wait_ready(BOOT_LIMIT, "reset");
		check("init capture count", 4, cap_q.size());
		for (int i = 0; i < 4; i++) begin
			check($sformatf("init lcd word %0d", i), {2'b00, exp_bytes[i]}, cap_q[i]);
		end
	endtask

	task automatic blank_refresh();
		run_refresh("blank refresh");
		check_frame("blank refresh");
	endtask

	task automatic char_writes();
		int         addr;
		logic [7:0] ch;
		for (int n = 0; n < 12; n++) begin
			addr = $random(seed) & (NUM_CHARS - 1);
			ch   = 8'h21 + 8'($random(seed) & 8'h3f); // printable range
			@(posedge clk);
			char_we   <= 1'b1;
			char_addr <= ADDR_W'(addr);
			char_data <= ch;
			model[addr] = ch;
		end
		@(posedge clk);
		char_we <= 1'b0;
		run_refresh("char refresh");
		check_frame("char refresh");
	endtask

	task automatic enable_timing();
		int gap;
		run_refresh("timing refresh");
		check_frame("timing refresh");
		check("lcd_e rise count", XFERS, rise_q.size());
		for (int i = 0; i < XFERS; i++) begin
			check($sformatf("lcd_e high cycles %0d", i),
				(E_FALL_US - E_RISE_US) * CYC_PER_US, fall_q[i] - rise_q[i]);
			if (i > 0) begin
				gap = rise_q[i] - rise_q[i-1];
				if (gap < XFER_US * CYC_PER_US) begin
					report_failure($sformatf("transfers %0d and %0d only %0d cycles apart",
						i - 1, i, gap));
				end
			end
		end
	endtask

	task automatic refresh_ignored_when_busy();
		cap_q.delete();
		pulse_refresh();
		repeat (1000) @(negedge clk);
		check("ready mid refresh", 0, ready);
		pulse_refresh(); // must be dropped
		wait_ready(REFRESH_LIMIT, "refresh with a second strobe");
		check_frame("busy refresh");
		repeat (2 * XFER_CYC) @(negedge clk);
		check("captures after ignored refresh", XFERS, cap_q.size());
		check("ready after ignored refresh", 1, ready);
	endtask

	initial begin
		seed      = 32'hd628;
		cfg       = 7'($random(seed));
		rst_n     = 1'b0;
		char_we   = 1'b0;
		char_addr = '0;
		char_data = 8'h00;
		refresh   = 1'b0;
		for (int i = 0; i < NUM_CHARS; i++) begin
			model[i] = BLANK_CHAR;
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		init_sequence();
		blank_refresh();
		char_writes();
		enable_timing();
		refresh_ignored_when_busy();
		$display("No errors");
		$finish;
	end
endmodule

/* sim.f */
source/lcd_pkg.sv
source/lcd_text_buffer.sv
source/lcd_refresh_seq.sv
source/lcd_controller.sv
source/lcd_display_top.sv
dv/lcd_sva.sv
dv/lcd_tb.sv

/* source/lcd_controller.sv */
`timescale 1ns/1ns
module lcd_controller
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] cfg,
	input  logic       lcd_enable,
	input  logic [9:0] lcd_bus,
	output logic       e,
	output logic [7:0] lcd_data,
	output logic       rw,
	output logic       rs,
	output logic       busy
);
	logic [1:0]       state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;
	logic [7:0]       func_set;
	logic [7:0]       disp_ctrl;
	logic [7:0]       entry_mode;
	logic             init_e;
	logic [7:0]       init_data;

	assign cnt_nxt = cnt + 1'b1;

	assign func_set   = OP_FUNC_SET | {4'b0000, cfg[CFG_LINES], cfg[CFG_FONT], 2'b00};
	assign disp_ctrl  = OP_DISP_CTRL | {5'b00000, cfg[CFG_DISP], cfg[CFG_CURSOR], cfg[CFG_BLINK]};
	assign entry_mode = OP_ENTRY_MODE | {6'b000000, cfg[CFG_INC], cfg[CFG_SHIFT]};

	// init schedule, data held one cycle past the e fall
	always_comb begin
		init_e    = 1'b0;
		init_data = 8'h00;
		if (cnt <= FS_END) begin
			init_e    = (cnt != FS_END);
			init_data = func_set;
		end else if (cnt >= DC_START && cnt <= DC_END) begin
			init_e    = (cnt != DC_END);
			init_data = disp_ctrl;
		end else if (cnt >= CLR_START && cnt <= CLR_END) begin
			init_e    = (cnt != CLR_END);
			init_data = OP_CLEAR;
		end else if (cnt >= EM_START && cnt <= EM_END) begin
			init_e    = (cnt != EM_END);
			init_data = entry_mode;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_PWR;
			cnt      <= '0;
			busy     <= 1'b1;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
		end else begin
			case (state)
				ST_PWR: begin
					busy <= 1'b1;
					if (cnt == CNT_W'(PWR_CYC - 1)) begin // power-up wait over
						cnt   <= '0;
						state <= ST_INIT;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				ST_INIT: begin
					busy     <= 1'b1;
					rs       <= 1'b0;
					rw       <= 1'b0;
					e        <= init_e;
					lcd_data <= init_data;
					if (cnt == CNT_W'(INIT_CYC - 1)) begin
						cnt   <= '0;
						busy  <= 1'b0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				ST_IDLE: begin
					e   <= 1'b0;
					cnt <= '0;
					if (lcd_enable) begin // latch the bus word
						busy     <= 1'b1;
						rs       <= lcd_bus[9];
						rw       <= lcd_bus[8];
						lcd_data <= lcd_bus[7:0];
						state    <= ST_XFER;
					end else begin
						busy     <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
					end
				end
				ST_XFER: begin
					// e high over [E_RISE_CYC, E_FALL_CYC) of the transfer
					e <= (cnt_nxt >= CNT_W'(E_RISE_CYC)) && (cnt_nxt < CNT_W'(E_FALL_CYC));
					if (cnt == CNT_W'(XFER_CYC - 1)) begin // full instruction time spent
						cnt   <= '0;
						busy  <= 1'b0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				default: state <= ST_PWR;
			endcase
		end
	end
endmodule

/* source/lcd_display_top.sv */
`timescale 1ns/1ns
module lcd_display_top
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [6:0]        cfg,
	input  logic              char_we,
	input  logic [ADDR_W-1:0] char_addr,
	input  logic [7:0]        char_data,
	input  logic              refresh,
	output logic              ready,
	output logic              lcd_e,
	output logic              lcd_rs,
	output logic              lcd_rw,
	output logic [7:0]        lcd_data
);
	logic [ADDR_W-1:0] rd_addr;
	logic [7:0]        rd_data;
	logic              seq_enable;
	logic [9:0]        seq_bus;    // {rs, rw, data}
	logic              ctrl_busy;

	lcd_text_buffer u_buf (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (char_we),
		.wr_addr (char_addr),
		.wr_data (char_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	lcd_refresh_seq u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.refresh    (refresh),
		.busy       (ctrl_busy),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.lcd_enable (seq_enable),
		.lcd_bus    (seq_bus),
		.ready      (ready)
	);

	lcd_controller u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.lcd_enable (seq_enable),
		.lcd_bus    (seq_bus),
		.e          (lcd_e),
		.lcd_data   (lcd_data),
		.rw         (lcd_rw),
		.rs         (lcd_rs),
		.busy       (ctrl_busy)
	);
endmodule

/* source/lcd_pkg.sv */
package lcd_pkg;
	localparam int CYC_PER_US   = 10;  // clock is 10 MHz
	localparam int PWR_US       = 500;
	localparam int PULSE_US     = 10;  // init enable window
	localparam int INIT_GAP_US  = 50;
	localparam int CLEAR_GAP_US = 200; // clear is the slow one
	localparam int ENTRY_GAP_US = 100;
	localparam int XFER_US      = 50;
	localparam int E_RISE_US    = 1;
	localparam int E_FALL_US    = 14;
	localparam int CNT_W        = 13;  // holds PWR_US * CYC_PER_US

	localparam int PWR_CYC    = PWR_US * CYC_PER_US;
	localparam int FS_END     = PULSE_US * CYC_PER_US;
	localparam int DC_START   = FS_END + INIT_GAP_US * CYC_PER_US;
	localparam int DC_END     = DC_START + PULSE_US * CYC_PER_US;
	localparam int CLR_START  = DC_END + INIT_GAP_US * CYC_PER_US;
	localparam int CLR_END    = CLR_START + PULSE_US * CYC_PER_US;
	localparam int EM_START   = CLR_END + CLEAR_GAP_US * CYC_PER_US;
	localparam int EM_END     = EM_START + PULSE_US * CYC_PER_US;
	localparam int INIT_CYC   = EM_END + ENTRY_GAP_US * CYC_PER_US; // 440 us total
	localparam int XFER_CYC   = XFER_US * CYC_PER_US;
	localparam int E_RISE_CYC = E_RISE_US * CYC_PER_US;
	localparam int E_FALL_CYC = E_FALL_US * CYC_PER_US;

	localparam logic [7:0] OP_FUNC_SET   = 8'h30; // 8-bit interface
	localparam logic [7:0] OP_DISP_CTRL  = 8'h08;
	localparam logic [7:0] OP_CLEAR      = 8'h01;
	localparam logic [7:0] OP_ENTRY_MODE = 8'h04;
	localparam logic [7:0] OP_SET_DDRAM  = 8'h80;

	localparam int CFG_LINES  = 6;
	localparam int CFG_FONT   = 5;
	localparam int CFG_DISP   = 4;
	localparam int CFG_CURSOR = 3;
	localparam int CFG_BLINK  = 2;
	localparam int CFG_INC    = 1;
	localparam int CFG_SHIFT  = 0;

	localparam int         LINE_LEN   = 16;
	localparam int         NUM_CHARS  = 32;
	localparam int         ADDR_W     = 5;
	localparam logic [7:0] LINE1_BASE = 8'h40;
	localparam logic [7:0] BLANK_CHAR = 8'h20; // ascii space

	localparam logic [1:0] ST_PWR  = 2'd0;
	localparam logic [1:0] ST_INIT = 2'd1;
	localparam logic [1:0] ST_IDLE = 2'd2;
	localparam logic [1:0] ST_XFER = 2'd3;

	localparam logic [2:0] SQ_IDLE  = 3'd0;
	localparam logic [2:0] SQ_ADDR  = 3'd1;
	localparam logic [2:0] SQ_FETCH = 3'd2;
	localparam logic [2:0] SQ_ISSUE = 3'd3;
	localparam logic [2:0] SQ_WAIT  = 3'd4;
endpackage

/* source/lcd_refresh_seq.sv */
`timescale 1ns/1ns
module lcd_refresh_seq
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              refresh,
	input  logic              busy,
	input  logic [7:0]        rd_data,
	output logic [ADDR_W-1:0] rd_addr,
	output logic              lcd_enable,
	output logic [9:0]        lcd_bus,
	output logic              ready
);
	logic [2:0]        state;
	logic [ADDR_W-1:0] idx;       // character being sent
	logic              booted;    // controller has left init
	logic              cmd_sent;  // line address already issued
	logic              line_start;
	logic [7:0]        line_base;

	assign rd_addr    = idx;
	assign ready      = (state == SQ_IDLE) && booted;
	assign line_start = (idx == '0) || (idx == ADDR_W'(LINE_LEN));
	assign line_base  = (idx < ADDR_W'(LINE_LEN)) ? 8'h00 : LINE1_BASE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= SQ_IDLE;
			idx        <= '0;
			booted     <= 1'b0;
			cmd_sent   <= 1'b0;
			lcd_enable <= 1'b0;
		end else begin
			lcd_enable <= 1'b0; // single-cycle strobe
			if (!busy) begin
				booted <= 1'b1;
			end
			case (state)
				SQ_IDLE: begin
					if (refresh && ready) begin
						idx      <= '0;
						cmd_sent <= 1'b0;
						state    <= SQ_ADDR;
					end
				end
				SQ_ADDR: begin
					if (line_start && !cmd_sent) begin
						cmd_sent <= 1'b1;
						state    <= SQ_ISSUE;
					end else begin
						state <= SQ_FETCH; // rd_data valid next cycle
					end
				end
				SQ_FETCH: state <= SQ_ISSUE;
				SQ_ISSUE: begin
					if (!busy) begin
						lcd_enable <= 1'b1;
						state      <= SQ_WAIT;
					end
				end
				SQ_WAIT: begin
					// busy is still low while the strobe is out
					if (!lcd_enable && !busy) begin
						if (!lcd_bus[9]) begin
							state <= SQ_ADDR; // address done, now the char
						end else if (idx == ADDR_W'(NUM_CHARS - 1)) begin
							state <= SQ_IDLE;
						end else begin
							idx      <= idx + 1'b1;
							cmd_sent <= 1'b0;
							state    <= SQ_ADDR;
						end
					end
				end
				default: state <= SQ_IDLE;
			endcase
		end
	end

	// bus word, rw always low
	always_ff @(posedge clk) begin
		if (state == SQ_ADDR && line_start && !cmd_sent) begin
			lcd_bus <= {2'b00, OP_SET_DDRAM | line_base};
		end else if (state == SQ_FETCH) begin
			lcd_bus <= {2'b10, rd_data};
		end
	end
endmodule

/* source/lcd_text_buffer.sv */
`timescale 1ns/1ns
module lcd_text_buffer
	import lcd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              we,
	input  logic [ADDR_W-1:0] wr_addr,
	input  logic [7:0]        wr_data,
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [7:0]        rd_data
);
	logic [7:0] mem [NUM_CHARS]; // line 0 at 0..15, line 1 at 16..31

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CHARS; i++) begin
				mem[i] <= BLANK_CHAR; // screen comes up blank
			end
		end else if (we) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// a same-cycle write to rd_addr shows up on the next read
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end
endmodule
